// File: logic/alu32.sv
`timescale 1ns/10ps

module alu32 import exec_pkg::*; #(
  parameter int data_w = 32
) (
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  input  logic              carry_in,
  input  alu_op_e           alu_op,
  input  data_size_e        data_size,
  output logic [data_w-1:0] result,
  output logic [data_w-1:0] flags
);

  logic [data_w-1:0] mask;
  logic [data_w-1:0] a_s;
  logic [data_w-1:0] b_s;
  logic [data_w-1:0] res;
  logic [data_w:0]   wide;
  logic              is_arith;
  logic              is_sub;
  int                msb;

  always_comb begin
    msb  = data_w - 1;
    mask = '1;
    case (data_size)
      size_byte: begin
        msb  = 7;
        mask = data_w'(8'hff);
      end
      size_word: begin
        msb  = 15;
        mask = data_w'(16'hffff);
      end
      default: ;
    endcase
  end

  assign a_s = a & mask;
  assign b_s = b & mask;

  // extra top bit catches carry or borrow out of the sized msb
  always_comb begin
    case (alu_op)
      alu_add: wide = {1'b0, a_s} + {1'b0, b_s};
      alu_adc: wide = {1'b0, a_s} + {1'b0, b_s} + {{data_w{1'b0}}, carry_in};
      alu_sub: wide = {1'b0, a_s} - {1'b0, b_s};
      alu_sbb: wide = {1'b0, a_s} - {1'b0, b_s} - {{data_w{1'b0}}, carry_in};
      alu_and: wide = {1'b0, a_s & b_s};
      alu_or:  wide = {1'b0, a_s | b_s};
      alu_xor: wide = {1'b0, a_s ^ b_s};
      default: wide = {1'b0, b_s};
    endcase
  end

  assign res      = wide[data_w-1:0] & mask;
  assign is_arith = alu_op inside {alu_add, alu_adc, alu_sub, alu_sbb};
  assign is_sub   = alu_op inside {alu_sub, alu_sbb};

  always_comb begin
    flags          = '0;
    flags[flag_zf] = (res == '0);
    flags[flag_sf] = res[msb];
    flags[flag_pf] = ~^res[7:0];
    if (is_arith) begin
      flags[flag_cf] = wide[msb+1];
      flags[flag_af] = a_s[4] ^ b_s[4] ^ res[4];
      // overflow when the result sign disagrees with the operand signs
      if (is_sub)
        flags[flag_of] = (a_s[msb] != b_s[msb]) && (res[msb] != a_s[msb]);
      else
        flags[flag_of] = (a_s[msb] == b_s[msb]) && (res[msb] != a_s[msb]);
    end
  end

  assign result = res;

endmodule

// File: logic/ex_wb_if.sv
`timescale 1ns/10ps

interface ex_wb_if #(
  parameter int data_w = 32,
  parameter int dr_w   = 3,
  parameter int eip_w  = 32
);

  logic              v;
  logic [eip_w-1:0]  neip;
  logic [data_w-1:0] result_a;
  logic [data_w-1:0] result_b;
  logic [data_w-1:0] flags;
  logic              ld_gpr1;
  logic              ld_gpr2;
  logic [dr_w-1:0]   dr1;
  logic [dr_w-1:0]   dr2;

  // execute side
  modport producer (
    output v, neip, result_a, result_b, flags, ld_gpr1, ld_gpr2, dr1, dr2
  );

  // wb latch side
  modport latch (
    input v, neip, result_a, result_b, flags, ld_gpr1, ld_gpr2, dr1, dr2
  );

endinterface

// File: logic/ex_wb_latch.sv
`timescale 1ns/10ps

module ex_wb_latch #(
  parameter int data_w = 32,
  parameter int dr_w   = 3,
  parameter int eip_w  = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wb_stall,
  ex_wb_if.latch            wb,
  output logic              wb_v,
  output logic [eip_w-1:0]  wb_neip,
  output logic [data_w-1:0] wb_result_a,
  output logic [data_w-1:0] wb_result_b,
  output logic [data_w-1:0] wb_flags,
  output logic              wb_ld_gpr1,
  output logic              wb_ld_gpr2,
  output logic [dr_w-1:0]   wb_dr1,
  output logic [dr_w-1:0]   wb_dr2
);

  // loads never escape without a valid uop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_v       <= 1'b0;
      wb_ld_gpr1 <= 1'b0;
      wb_ld_gpr2 <= 1'b0;
    end else if (!wb_stall) begin
      wb_v       <= wb.v;
      wb_ld_gpr1 <= wb.ld_gpr1 & wb.v;
      wb_ld_gpr2 <= wb.ld_gpr2 & wb.v;
    end
  end

  always_ff @(posedge clk) begin
    if (!wb_stall) begin
      wb_neip     <= wb.neip;
      wb_result_a <= wb.result_a;
      wb_result_b <= wb.result_b;
      wb_flags    <= wb.flags;
      wb_dr1      <= wb.dr1;
      wb_dr2      <= wb.dr2;
    end
  end

  // stalled uop must reach the latch unchanged
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    wb_stall |=> $stable({wb.v, wb.neip, wb.result_a, wb.result_b, wb.flags,
                          wb.ld_gpr1, wb.ld_gpr2, wb.dr1, wb.dr2}));

endmodule

// File: logic/exec_pkg.sv
package exec_pkg;

  // alu operation, decoded per uop
  typedef enum logic [2:0] {
    alu_add    = 3'd0,
    alu_adc    = 3'd1,
    alu_sub    = 3'd2,
    alu_sbb    = 3'd3,
    alu_and    = 3'd4,
    alu_or     = 3'd5,
    alu_xor    = 3'd6,
    alu_pass_b = 3'd7
  } alu_op_e;

  typedef enum logic {
    shift_shl = 1'b0,
    shift_shr = 1'b1
  } shift_dir_e;

  // unit feeding result a
  typedef enum logic [1:0] {
    fu_alu    = 2'd0,
    fu_shift  = 2'd1,
    fu_pass_a = 2'd2
  } fu_sel_e;

  typedef enum logic [2:0] {
    uop_plain       = 3'd0,
    uop_xchg        = 3'd1,
    uop_cmpxchg     = 3'd2,
    uop_cmps_first  = 3'd3,
    uop_cmps_second = 3'd4
  } uop_kind_e;

  typedef enum logic [1:0] {
    size_byte  = 2'd0,
    size_word  = 2'd1,
    size_dword = 2'd2
  } data_size_e;

  // x86 eflags bit positions
  localparam int flag_cf = 0;
  localparam int flag_pf = 2;
  localparam int flag_af = 4;
  localparam int flag_zf = 6;
  localparam int flag_sf = 7;
  localparam int flag_of = 11;

endpackage

// File: logic/exec_stage_top.sv
`timescale 1ns/10ps

module exec_stage_top import exec_pkg::*; #(
  parameter int data_w = 32,
  parameter int dr_w   = 3,
  parameter int eip_w  = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ex_v,
  input  logic [eip_w-1:0]  ex_neip,
  input  alu_op_e           ex_alu_op,
  input  shift_dir_e        ex_shift_dir,
  input  fu_sel_e           ex_fu_sel,
  input  uop_kind_e         ex_uop_kind,
  input  data_size_e        ex_data_size,
  input  logic              ex_ld_gpr1,
  input  logic              ex_ld_gpr2,
  input  logic [data_w-1:0] ex_a,
  input  logic [data_w-1:0] ex_b,
  input  logic [data_w-1:0] ex_c,
  input  logic [dr_w-1:0]   ex_dr1,
  input  logic [dr_w-1:0]   ex_dr2,
  input  logic              wb_stall,
  output logic              ld_latches,
  output logic              dep_ld_gpr1,
  output logic              dep_ld_gpr2,
  output logic              wb_v,
  output logic [eip_w-1:0]  wb_neip,
  output logic [data_w-1:0] wb_result_a,
  output logic [data_w-1:0] wb_result_b,
  output logic [data_w-1:0] wb_flags,
  output logic              wb_ld_gpr1,
  output logic              wb_ld_gpr2,
  output logic [dr_w-1:0]   wb_dr1,
  output logic [dr_w-1:0]   wb_dr2
);

  ex_wb_if #(.data_w(data_w), .dr_w(dr_w), .eip_w(eip_w)) ex_wb ();

  // upstream holds its inputs while writeback stalls
  assign ld_latches = ~wb_stall;

  execute #(.data_w(data_w), .dr_w(dr_w), .eip_w(eip_w)) u_execute (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_v         (ex_v),
    .ex_neip      (ex_neip),
    .ex_alu_op    (ex_alu_op),
    .ex_shift_dir (ex_shift_dir),
    .ex_fu_sel    (ex_fu_sel),
    .ex_uop_kind  (ex_uop_kind),
    .ex_data_size (ex_data_size),
    .ex_ld_gpr1   (ex_ld_gpr1),
    .ex_ld_gpr2   (ex_ld_gpr2),
    .ex_a         (ex_a),
    .ex_b         (ex_b),
    .ex_c         (ex_c),
    .ex_dr1       (ex_dr1),
    .ex_dr2       (ex_dr2),
    .wb_stall     (wb_stall),
    .dep_ld_gpr1  (dep_ld_gpr1),
    .dep_ld_gpr2  (dep_ld_gpr2),
    .wb           (ex_wb.producer)
  );

  ex_wb_latch #(.data_w(data_w), .dr_w(dr_w), .eip_w(eip_w)) u_ex_wb_latch (
    .clk         (clk),
    .rst_n       (rst_n),
    .wb_stall    (wb_stall),
    .wb          (ex_wb.latch),
    .wb_v        (wb_v),
    .wb_neip     (wb_neip),
    .wb_result_a (wb_result_a),
    .wb_result_b (wb_result_b),
    .wb_flags    (wb_flags),
    .wb_ld_gpr1  (wb_ld_gpr1),
    .wb_ld_gpr2  (wb_ld_gpr2),
    .wb_dr1      (wb_dr1),
    .wb_dr2      (wb_dr2)
  );

endmodule

// File: logic/execute.sv
`timescale 1ns/10ps

module execute import exec_pkg::*; #(
  parameter int data_w = 32,
  parameter int dr_w   = 3,
  parameter int eip_w  = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ex_v,
  input  logic [eip_w-1:0]  ex_neip,
  input  alu_op_e           ex_alu_op,
  input  shift_dir_e        ex_shift_dir,
  input  fu_sel_e           ex_fu_sel,
  input  uop_kind_e         ex_uop_kind,
  input  data_size_e        ex_data_size,
  input  logic              ex_ld_gpr1,
  input  logic              ex_ld_gpr2,
  input  logic [data_w-1:0] ex_a,
  input  logic [data_w-1:0] ex_b,
  input  logic [data_w-1:0] ex_c,
  input  logic [dr_w-1:0]   ex_dr1,
  input  logic [dr_w-1:0]   ex_dr2,
  input  logic              wb_stall,
  output logic              dep_ld_gpr1,
  output logic              dep_ld_gpr2,
  ex_wb_if.producer         wb
);

  logic              accept;
  logic [data_w-1:0] operand_b;
  logic [data_w-1:0] alu_result;
  logic [data_w-1:0] alu_flags;
  logic [data_w-1:0] shift_result;
  logic [data_w-1:0] shift_flags;
  logic [data_w-1:0] flags;
  logic [4:0]        shift_count;
  logic [5:0]        size_bits;
  logic              zf;
  logic              ld_gpr1;
  logic              ld_gpr2;

  assign accept      = ex_v & ~wb_stall;
  assign shift_count = operand_b[4:0];

  operand_select_ex #(.data_w(data_w)) u_operand_select_ex (
    .clk       (clk),
    .rst_n     (rst_n),
    .accept    (accept),
    .uop_kind  (ex_uop_kind),
    .a         (ex_a),
    .b         (ex_b),
    .c         (ex_c),
    .operand_b (operand_b)
  );

  // adc and sbb run with carry 0 here
  alu32 #(.data_w(data_w)) u_alu32 (
    .a         (ex_a),
    .b         (operand_b),
    .carry_in  (1'b0),
    .alu_op    (ex_alu_op),
    .data_size (ex_data_size),
    .result    (alu_result),
    .flags     (alu_flags)
  );

  shifter32 #(.data_w(data_w)) u_shifter32 (
    .a         (ex_a),
    .count     (shift_count),
    .shift_dir (ex_shift_dir),
    .data_size (ex_data_size),
    .result    (shift_result),
    .flags     (shift_flags)
  );

  result_select_ex #(.data_w(data_w)) u_result_select_ex (
    .fu_sel       (ex_fu_sel),
    .uop_kind     (ex_uop_kind),
    .a            (ex_a),
    .b            (ex_b),
    .alu_result   (alu_result),
    .alu_flags    (alu_flags),
    .shift_result (shift_result),
    .shift_flags  (shift_flags),
    .result_a     (wb.result_a),
    .result_b     (wb.result_b),
    .flags        (flags)
  );

  assign zf = flags[flag_zf];

  // cmpxchg: dest on match, accumulator on mismatch
  always_comb begin
    ld_gpr1 = ex_ld_gpr1;
    ld_gpr2 = ex_ld_gpr2;
    case (ex_uop_kind)
      uop_cmpxchg: begin
        ld_gpr1 = zf;
        ld_gpr2 = ~zf;
      end
      uop_cmps_first, uop_cmps_second: begin
        ld_gpr1 = 1'b0;
        ld_gpr2 = 1'b0;
      end
      default: ;
    endcase
  end

  assign dep_ld_gpr1 = ld_gpr1 & ex_v;
  assign dep_ld_gpr2 = ld_gpr2 & ex_v;

  assign wb.v       = ex_v;
  assign wb.neip    = ex_neip;
  assign wb.flags   = flags;
  assign wb.ld_gpr1 = ld_gpr1;
  assign wb.ld_gpr2 = ld_gpr2;
  assign wb.dr1     = ex_dr1;
  assign wb.dr2     = ex_dr2;

  assign size_bits = (ex_data_size == size_byte) ? 6'd8 :
                     (ex_data_size == size_word) ? 6'd16 : 6'(data_w);

  // shift count comes from operand b, only meaningful on shift uops
  a_shift_count: assert property (@(posedge clk) disable iff (!rst_n)
    (accept && ex_fu_sel == fu_shift) |-> ({1'b0, shift_count} <= size_bits));

endmodule

// File: logic/operand_select_ex.sv
`timescale 1ns/10ps

module operand_select_ex import exec_pkg::*; #(
  parameter int data_w = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              accept,
  input  uop_kind_e         uop_kind,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  input  logic [data_w-1:0] c,
  output logic [data_w-1:0] operand_b
);

  logic [data_w-1:0] saved_q;
  logic              saved_v_q;

  // first half of a string compare parks its operand here
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      saved_q   <= '0;
      saved_v_q <= 1'b0;
    end else if (accept && uop_kind == uop_cmps_first) begin
      saved_q   <= a;
      saved_v_q <= 1'b1;
    end
  end

  always_comb begin
    case (uop_kind)
      uop_cmpxchg:     operand_b = c;
      uop_cmps_second: operand_b = saved_q;
      default:         operand_b = b;
    endcase
  end

  a_cmps_order: assert property (@(posedge clk) disable iff (!rst_n)
    (accept && uop_kind == uop_cmps_second) |-> saved_v_q);

endmodule

// File: logic/result_select_ex.sv
`timescale 1ns/10ps

module result_select_ex import exec_pkg::*; #(
  parameter int data_w = 32
) (
  input  fu_sel_e           fu_sel,
  input  uop_kind_e         uop_kind,
  input  logic [data_w-1:0] a,
  input  logic [data_w-1:0] b,
  input  logic [data_w-1:0] alu_result,
  input  logic [data_w-1:0] alu_flags,
  input  logic [data_w-1:0] shift_result,
  input  logic [data_w-1:0] shift_flags,
  output logic [data_w-1:0] result_a,
  output logic [data_w-1:0] result_b,
  output logic [data_w-1:0] flags
);

  logic [data_w-1:0] fu_result;

  always_comb begin
    case (fu_sel)
      fu_shift:  fu_result = shift_result;
      fu_pass_a: fu_result = a;
      default:   fu_result = alu_result;
    endcase
  end

  // exchanges hand each operand to the other register
  always_comb begin
    case (uop_kind)
      uop_xchg, uop_cmpxchg: begin
        result_a = b;
        result_b = a;
      end
      default: begin
        result_a = fu_result;
        result_b = b;
      end
    endcase
  end

  // compare in cmpxchg runs through the alu, so its flags follow fu_sel too
  always_comb begin
    if (fu_sel == fu_shift)
      flags = shift_flags;
    else
      flags = alu_flags;
  end

endmodule

// File: logic/shifter32.sv
`timescale 1ns/10ps

module shifter32 import exec_pkg::*; #(
  parameter int data_w = 32
) (
  input  logic [data_w-1:0] a,
  input  logic [4:0]        count,
  input  shift_dir_e        shift_dir,
  input  data_size_e        data_size,
  output logic [data_w-1:0] result,
  output logic [data_w-1:0] flags
);

  logic [data_w-1:0] mask;
  logic [data_w-1:0] a_s;
  logic [data_w-1:0] res;
  logic              cf;
  int                width;

  always_comb begin
    width = data_w;
    mask  = '1;
    case (data_size)
      size_byte: begin
        width = 8;
        mask  = data_w'(8'hff);
      end
      size_word: begin
        width = 16;
        mask  = data_w'(16'hffff);
      end
      default: ;
    endcase
  end

  assign a_s = a & mask;

  // cf holds the last bit pushed out of the sized value
  always_comb begin
    cf = 1'b0;
    if (shift_dir == shift_shl) begin
      res = (a_s << count) & mask;
      if (count != 0 && count <= width)
        cf = a_s[width - count];
    end else begin
      res = a_s >> count;
      if (count != 0)
        cf = a_s[count - 1];
    end
  end

  always_comb begin
    flags          = '0;
    flags[flag_cf] = cf;
    flags[flag_zf] = (res == '0);
    flags[flag_sf] = res[width - 1];
    flags[flag_pf] = ~^res[7:0];
  end

  assign result = res;

endmodule

// File: verif/exec_model.svh
`ifndef exec_model_svh
`define exec_model_svh

typedef struct packed {
  logic [31:0] result_a;
  logic [31:0] result_b;
  logic [31:0] flags;
  logic        ld1;
  logic        ld2;
} uop_exp_t;

function automatic int size_width(input data_size_e size);
  case (size)
    size_byte: return 8;
    size_word: return 16;
    default:   return 32;
  endcase
endfunction

function automatic logic [31:0] size_mask(input data_size_e size);
  return 32'((longint'(1) << size_width(size)) - 1);
endfunction

// zf, sf and pf of a sized result
function automatic logic [31:0] result_flags(input logic [31:0] res, input data_size_e size);
  logic [31:0] fl;
  fl          = '0;
  fl[flag_zf] = (res == 32'h0);
  fl[flag_sf] = res[size_width(size) - 1];
  fl[flag_pf] = ~^res[7:0];
  return fl;
endfunction

// returns {flags, result}; carry in is zero, so adc and sbb act as add and sub
function automatic logic [63:0] alu_ref(input alu_op_e op, input data_size_e size,
                                        input logic [31:0] a, input logic [31:0] b);
  longint      ua;
  longint      ub;
  longint      ur;
  longint      sa;
  longint      sb;
  longint      sr;
  longint      half;
  logic [31:0] res;
  logic [31:0] fl;
  logic        arith;
  ua    = longint'(a & size_mask(size));
  ub    = longint'(b & size_mask(size));
  half  = longint'(1) << (size_width(size) - 1);
  sa    = (ua >= half) ? ua - 2 * half : ua;
  sb    = (ub >= half) ? ub - 2 * half : ub;
  fl    = '0;
  arith = 1'b1;
  sr    = 0;
  case (op)
    alu_add, alu_adc: begin
      ur          = ua + ub;
      sr          = sa + sb;
      fl[flag_cf] = (ur >= 2 * half);
      fl[flag_af] = ((ua % 16) + (ub % 16)) > 15;
    end
    alu_sub, alu_sbb: begin
      ur          = ua - ub;
      sr          = sa - sb;
      fl[flag_cf] = (ua < ub);
      fl[flag_af] = (ua % 16) < (ub % 16);
    end
    alu_and: ur = ua & ub;
    alu_or:  ur = ua | ub;
    alu_xor: ur = ua ^ ub;
    default: ur = ub;
  endcase
  if (!(op inside {alu_add, alu_adc, alu_sub, alu_sbb}))
    arith = 1'b0;
  if (arith)
    fl[flag_of] = (sr >= half) || (sr < -half);
  res = 32'(ur) & size_mask(size);
  fl  = fl | result_flags(res, size);
  return {fl, res};
endfunction

function automatic logic [63:0] shift_ref(input logic [31:0] a, input logic [4:0] count,
                                          input shift_dir_e dir, input data_size_e size);
  longint      ua;
  longint      full;
  int          cnt;
  logic [31:0] res;
  logic [31:0] fl;
  ua  = longint'(a & size_mask(size));
  cnt = count;
  fl  = '0;
  if (dir == shift_shl) begin
    full        = ua << cnt;
    res         = 32'(full) & size_mask(size);
    // bit just above the sized msb is the last one pushed out
    fl[flag_cf] = (cnt != 0) && full[size_width(size)];
  end else begin
    res         = 32'(ua >> cnt);
    fl[flag_cf] = (cnt != 0) && (((ua >> (cnt - 1)) & 1) != 0);
  end
  fl = fl | result_flags(res, size);
  return {fl, res};
endfunction

function automatic uop_exp_t uop_ref(input alu_op_e op, input shift_dir_e dir,
                                     input fu_sel_e fu, input uop_kind_e kind,
                                     input data_size_e size, input logic ld1,
                                     input logic ld2, input logic [31:0] a,
                                     input logic [31:0] b, input logic [31:0] c,
                                     input logic [31:0] saved);
  uop_exp_t    e;
  logic [31:0] opb;
  logic [31:0] fu_res;
  logic [63:0] alu_out;
  logic [63:0] sh_out;
  opb     = (kind == uop_cmpxchg) ? c : (kind == uop_cmps_second) ? saved : b;
  alu_out = alu_ref(op, size, a, opb);
  sh_out  = shift_ref(a, opb[4:0], dir, size);
  case (fu)
    fu_shift:  fu_res = sh_out[31:0];
    fu_pass_a: fu_res = a;
    default:   fu_res = alu_out[31:0];
  endcase
  e.flags = (fu == fu_shift) ? sh_out[63:32] : alu_out[63:32];
  if (kind == uop_xchg || kind == uop_cmpxchg) begin
    e.result_a = b;
    e.result_b = a;
  end else begin
    e.result_a = fu_res;
    e.result_b = b;
  end
  e.ld1 = ld1;
  e.ld2 = ld2;
  if (kind == uop_cmpxchg) begin
    e.ld1 = e.flags[flag_zf];
    e.ld2 = !e.flags[flag_zf];
  end else if (kind == uop_cmps_first || kind == uop_cmps_second) begin
    e.ld1 = 1'b0;
    e.ld2 = 1'b0;
  end
  return e;
endfunction

`endif

// File: verif/exec_tb.sv
`timescale 1ns/10ps

module exec_tb import exec_pkg::*; ();

  `include "exec_model.svh"

  localparam int n_uops     = 2000;
  localparam int clk_period = 8;
  localparam int timeout_ns = n_uops * 8 * clk_period;

  logic        clk;
  logic        rst_n;
  logic        ex_v;
  logic [31:0] ex_neip;
  alu_op_e     ex_alu_op;
  shift_dir_e  ex_shift_dir;
  fu_sel_e     ex_fu_sel;
  uop_kind_e   ex_uop_kind;
  data_size_e  ex_data_size;
  logic        ex_ld_gpr1;
  logic        ex_ld_gpr2;
  logic [31:0] ex_a;
  logic [31:0] ex_b;
  logic [31:0] ex_c;
  logic [2:0]  ex_dr1;
  logic [2:0]  ex_dr2;
  logic        wb_stall;
  logic        ld_latches;
  logic        dep_ld_gpr1;
  logic        dep_ld_gpr2;
  logic        wb_v;
  logic [31:0] wb_neip;
  logic [31:0] wb_result_a;
  logic [31:0] wb_result_b;
  logic [31:0] wb_flags;
  logic        wb_ld_gpr1;
  logic        wb_ld_gpr2;
  logic [2:0]  wb_dr1;
  logic [2:0]  wb_dr2;

  // model state, written at the rising edge and checked at the falling edge
  logic [31:0] saved_op;
  logic        saved_valid;
  uop_exp_t    acc_exp;
  uop_exp_t    now_exp;
  logic        exp_v;
  logic [31:0] exp_neip;
  logic [31:0] exp_ra;
  logic [31:0] exp_rb;
  logic [31:0] exp_flags;
  logic        exp_ld1;
  logic        exp_ld2;
  logic [2:0]  exp_dr1;
  logic [2:0]  exp_dr2;
  int          accepted;
  logic        finishing;

  exec_stage_top #(.data_w(32), .dr_w(3), .eip_w(32)) exec_stage_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_v         (ex_v),
    .ex_neip      (ex_neip),
    .ex_alu_op    (ex_alu_op),
    .ex_shift_dir (ex_shift_dir),
    .ex_fu_sel    (ex_fu_sel),
    .ex_uop_kind  (ex_uop_kind),
    .ex_data_size (ex_data_size),
    .ex_ld_gpr1   (ex_ld_gpr1),
    .ex_ld_gpr2   (ex_ld_gpr2),
    .ex_a         (ex_a),
    .ex_b         (ex_b),
    .ex_c         (ex_c),
    .ex_dr1       (ex_dr1),
    .ex_dr2       (ex_dr2),
    .wb_stall     (wb_stall),
    .ld_latches   (ld_latches),
    .dep_ld_gpr1  (dep_ld_gpr1),
    .dep_ld_gpr2  (dep_ld_gpr2),
    .wb_v         (wb_v),
    .wb_neip      (wb_neip),
    .wb_result_a  (wb_result_a),
    .wb_result_b  (wb_result_b),
    .wb_flags     (wb_flags),
    .wb_ld_gpr1   (wb_ld_gpr1),
    .wb_ld_gpr2   (wb_ld_gpr2),
    .wb_dr1       (wb_dr1),
    .wb_dr2       (wb_dr2)
  );

  always #(clk_period / 2) clk = ~clk;

  task automatic fail_now(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else fail_now($sformatf("%s got %h expected %h", name, got, exp));
  endtask

  // corner values show up often enough to hit zero and carry cases
  function automatic logic [31:0] random_operand();
    case ($urandom_range(0, 7))
      0:       return 32'h0;
      1:       return 32'hffff_ffff;
      2:       return 32'($urandom_range(0, 15));
      default: return $urandom;
    endcase
  endfunction

  task automatic drive_new_uop();
    uop_kind_e   kind;
    fu_sel_e     fu;
    alu_op_e     op;
    data_size_e  size;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    int          width;
    case ($urandom_range(0, 9))
      0, 1:    kind = uop_xchg;
      2:       kind = uop_cmpxchg;
      3:       kind = uop_cmps_first;
      4:       kind = saved_valid ? uop_cmps_second : uop_cmps_first;
      default: kind = uop_plain;
    endcase
    size = data_size_e'($urandom_range(0, 2));
    op   = alu_op_e'($urandom_range(0, 7));
    fu   = fu_sel_e'($urandom_range(0, 2));
    a    = random_operand();
    b    = random_operand();
    c    = random_operand();
    // compares run as a subtract through the alu
    if (kind inside {uop_cmpxchg, uop_cmps_first, uop_cmps_second}) begin
      fu = fu_alu;
      op = alu_sub;
    end
    if (kind == uop_cmpxchg && $urandom_range(0, 2) == 0)
      c = a;
    if (kind == uop_cmps_second && $urandom_range(0, 2) == 0)
      a = saved_op;
    if (fu == fu_shift) begin
      width  = size_width(size);
      b[4:0] = 5'($urandom_range(0, (width > 31) ? 31 : width));
    end
    ex_v         <= ($urandom_range(0, 9) != 0);
    ex_neip      <= $urandom;
    ex_alu_op    <= op;
    ex_shift_dir <= shift_dir_e'($urandom_range(0, 1));
    ex_fu_sel    <= fu;
    ex_uop_kind  <= kind;
    ex_data_size <= size;
    ex_ld_gpr1   <= 1'($urandom_range(0, 1));
    ex_ld_gpr2   <= 1'($urandom_range(0, 1));
    ex_a         <= a;
    ex_b         <= b;
    ex_c         <= c;
    ex_dr1       <= 3'($urandom_range(0, 7));
    ex_dr2       <= 3'($urandom_range(0, 7));
  endtask

  initial begin
    void'($urandom(48));
    clk          = 1'b0;
    rst_n        = 1'b0;
    ex_v         = 1'b0;
    ex_neip      = '0;
    ex_alu_op    = alu_add;
    ex_shift_dir = shift_shl;
    ex_fu_sel    = fu_alu;
    ex_uop_kind  = uop_plain;
    ex_data_size = size_dword;
    ex_ld_gpr1   = 1'b0;
    ex_ld_gpr2   = 1'b0;
    ex_a         = '0;
    ex_b         = '0;
    ex_c         = '0;
    ex_dr1       = '0;
    ex_dr2       = '0;
    wb_stall     = 1'b0;
    saved_op     = '0;
    saved_valid  = 1'b0;
    exp_v        = 1'b0;
    exp_ld1      = 1'b0;
    exp_ld2      = 1'b0;
    accepted     = 0;
    finishing    = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    forever begin
      @(posedge clk);
      // latch loads on every edge without a stall
      if (!wb_stall) begin
        acc_exp = uop_ref(ex_alu_op, ex_shift_dir, ex_fu_sel, ex_uop_kind, ex_data_size,
                          ex_ld_gpr1, ex_ld_gpr2, ex_a, ex_b, ex_c, saved_op);
        exp_v     = ex_v;
        exp_neip  = ex_neip;
        exp_ra    = acc_exp.result_a;
        exp_rb    = acc_exp.result_b;
        exp_flags = acc_exp.flags;
        exp_ld1   = acc_exp.ld1 & ex_v;
        exp_ld2   = acc_exp.ld2 & ex_v;
        exp_dr1   = ex_dr1;
        exp_dr2   = ex_dr2;
        if (ex_v) begin
          accepted++;
          if (ex_uop_kind == uop_cmps_first) begin
            saved_op    = ex_a;
            saved_valid = 1'b1;
          end
        end
      end
      if (accepted >= n_uops) begin
        ex_v      <= 1'b0;
        finishing = 1'b1;
      end else if (!wb_stall) begin
        drive_new_uop();
      end
      wb_stall <= ($urandom_range(0, 4) == 0);
    end
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      assert (wb_v === 1'b0 && wb_ld_gpr1 === 1'b0 && wb_ld_gpr2 === 1'b0)
        else fail_now("wb valid or register loads not cleared during reset");
    end else begin
      now_exp = uop_ref(ex_alu_op, ex_shift_dir, ex_fu_sel, ex_uop_kind, ex_data_size,
                        ex_ld_gpr1, ex_ld_gpr2, ex_a, ex_b, ex_c, saved_op);
      check_value("ld_latches", ld_latches, !wb_stall);
      check_value("dep_ld_gpr1", dep_ld_gpr1, now_exp.ld1 & ex_v);
      check_value("dep_ld_gpr2", dep_ld_gpr2, now_exp.ld2 & ex_v);
      // cmpxchg writes the destination only on an accumulator match
      if (ex_v && ex_uop_kind == uop_cmpxchg)
        check_value("cmpxchg match", dep_ld_gpr1,
                    (ex_a & size_mask(ex_data_size)) == (ex_c & size_mask(ex_data_size)));
      check_value("wb_v", wb_v, exp_v);
      check_value("wb_ld_gpr1", wb_ld_gpr1, exp_ld1);
      check_value("wb_ld_gpr2", wb_ld_gpr2, exp_ld2);
      if (exp_v) begin
        check_value("wb_neip", wb_neip, exp_neip);
        check_value("wb_result_a", wb_result_a, exp_ra);
        check_value("wb_result_b", wb_result_b, exp_rb);
        check_value("wb_flags", wb_flags, exp_flags);
        check_value("wb_dr1", wb_dr1, exp_dr1);
        check_value("wb_dr2", wb_dr2, exp_dr2);
      end
      if (finishing) begin
        $display("Test completed successfully");
        $finish;
      end
    end
  end

  initial begin
    #(timeout_ns);
    $display("Timeout: the DUT did not take all uops within %0d ns", timeout_ns);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: verilog.f
+incdir+verif
logic/exec_pkg.sv
logic/ex_wb_if.sv
logic/operand_select_ex.sv
logic/alu32.sv
logic/shifter32.sv
logic/result_select_ex.sv
logic/execute.sv
logic/ex_wb_latch.sv
logic/exec_stage_top.sv
verif/exec_tb.sv
